//--- project.f
+incdir+design
design/mmio_pkg.sv
design/cpu_port.sv
design/mmio_router.sv
design/wb_port.sv
design/ext_reg_port.sv
design/display_port.sv
design/mmio_bridge.sv
testbench/tb_clock_gen.sv
testbench/tb_mmio_bridge.sv

//--- testbench/tb_mmio_bridge.sv
`timescale 1ns/100ps
`include "mmio_macros.svh"

module tb_mmio_bridge import mmio_pkg::*; ();

    localparam int NUM_ACCESS     = 300;
    localparam int TIMEOUT_CYCLES = NUM_ACCESS * 40;  // worst access is well below 40
    localparam word_t EDGE_ADDR [10] = '{0, 1024, 1025, 1056, 1057, 1792, 1793, 2047,
                                         2048, 4095};

    typedef enum {TGT_NONE, TGT_WB_RD, TGT_WB_WR, TGT_REG, TGT_DISP} target_t;

    logic      clk;
    logic      arst_n;
    req_kind_t req_kind;
    word_t     addr;
    word_t     wdata;
    logic      cpu_busy;
    logic      done;
    word_t     rdata;
    word_t     instr;
    logic      wb_busy;
    word_t     wb_rdata;            // manager to bridge
    logic      wb_read;
    logic      wb_write;
    word_t     wb_addr;
    word_t     wb_wdata;            // bridge to manager
    logic      reg_cs;
    logic      reg_ack;
    word_t     reg_data;
    logic      reg_read;
    reg_addr_t reg_addr;
    logic      disp_ack;
    logic      disp_write;
    word_t     disp_addr;
    word_t     disp_data;

    logic [31:0] lfsr_q;            // drawn from the main process only
    int        wb_wait_cfg;         // per access model delays
    int        wb_len_cfg;
    int        cs_gap_cfg;
    int        ack_wait_cfg;
    int        disp_wait_cfg;
    word_t     mem_tgt [64];        // memory seen by the manager model
    word_t     ref_mem [64];        // expected memory contents
    logic [1:0] wb_st;
    int        wb_cnt;
    int        cs_cnt;
    int        ack_cnt;
    logic      ack_pend;
    logic [1:0] disp_st;
    int        disp_cnt;
    word_t     log_addr [$];        // display writes as received
    word_t     log_data [$];
    int        n_wb_rd;
    int        n_wb_wr;
    int        n_reg_rd;
    int        n_disp_wr;
    logic      wb_read_q;
    logic      wb_write_q;
    logic      disp_write_q;
    logic      reg_cs_q;
    word_t     seen_wb_addr;
    word_t     seen_wb_wdata;
    reg_addr_t seen_reg_addr;
    int        cycle_cnt;

    tb_clock_gen clock_gen_inst (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mmio_bridge mmio_bridge_inst (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_kind_i   (req_kind),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .cpu_busy_o   (cpu_busy),
        .done_o       (done),
        .rdata_o      (rdata),
        .instr_o      (instr),
        .wb_busy_i    (wb_busy),
        .wb_data_i    (wb_rdata),
        .wb_read_o    (wb_read),
        .wb_write_o   (wb_write),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_wdata),
        .reg_cs_i     (reg_cs),
        .reg_ack_i    (reg_ack),
        .reg_data_i   (reg_data),
        .reg_read_o   (reg_read),
        .reg_addr_o   (reg_addr),
        .disp_ack_i   (disp_ack),
        .disp_write_o (disp_write),
        .disp_addr_o  (disp_addr),
        .disp_data_o  (disp_data)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);     // one step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic word_t mem_fill(input int idx);
        return word_t'(32'h6100_0000 ^ (idx * 32'h0102_0409));
    endfunction

    function automatic word_t reg_value(input int idx);
        return word_t'(32'hC0DE_0000 | (idx << 8) | (~idx & 8'hFF));
    endfunction

    function automatic word_t pick_addr();
        logic [2:0] sel;
        sel = take_bits(3);
        case (sel)
            3'd0, 3'd1: return take_bits(11) % (`MMIO_INSTR_TOP + 1);
            3'd2:       return `MMIO_INSTR_TOP + 1 + take_bits(5);
            3'd3, 3'd4: return `MMIO_REG_TOP + 1 + take_bits(10) % 736;
            3'd5:       return `MMIO_DATA_TOP + 1 + take_bits(8) % 255;
            3'd6:       return `MMIO_DISP_TOP + 1 + take_bits(11);  // unmapped
            default:    return EDGE_ADDR[take_bits(4) % 10];
        endcase
    endfunction

    // which target an access should reach by the decode rules
    function automatic target_t expect_target(input req_kind_t k, input word_t a);
        if (a > `MMIO_DISP_TOP)
            return TGT_NONE;
        if (a > `MMIO_DATA_TOP)
            return (k == REQ_WRITE) ? TGT_DISP : TGT_NONE;
        if (a > `MMIO_REG_TOP)
            return (k == REQ_WRITE) ? TGT_WB_WR : TGT_WB_RD;
        if (a > `MMIO_INSTR_TOP)
            return (k == REQ_READ) ? TGT_REG : TGT_NONE;
        return (k == REQ_WRITE) ? TGT_NONE : TGT_WB_RD;  // instr memory is read only
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // wishbone manager model with a busy pulse after a random delay
    always @(posedge clk) begin
        case (wb_st)
            2'd0: if (wb_read || wb_write) begin
                wb_cnt <= wb_wait_cfg;
                wb_st  <= 2'd1;
            end
            2'd1: if (wb_cnt == 0) begin
                wb_busy <= 1'b1;
                wb_cnt  <= wb_len_cfg;
                wb_st   <= 2'd2;
            end else begin
                wb_cnt <= wb_cnt - 1;
            end
            2'd2: if (wb_cnt <= 1) begin
                wb_busy  <= 1'b0;                   // falling edge ends the access
                wb_rdata <= mem_tgt[wb_addr[7:2]];
                if (wb_write)
                    mem_tgt[wb_addr[7:2]] <= wb_wdata;
                wb_st <= 2'd3;
            end else begin
                wb_cnt <= wb_cnt - 1;
            end
            default: if (!wb_read && !wb_write)
                wb_st <= 2'd0;                      // wait for strobe release
        endcase
    end

    // register bank with free running chip select and delayed ack
    always @(posedge clk) begin
        reg_cs   <= 1'b0;
        reg_ack  <= 1'b0;
        reg_data <= '0;
        if (cs_cnt == 0) begin
            reg_cs <= 1'b1;
            cs_cnt <= cs_gap_cfg;
        end else begin
            cs_cnt <= cs_cnt - 1;
        end
        if (reg_read) begin
            ack_pend <= 1'b1;
            ack_cnt  <= ack_wait_cfg;
        end else if (ack_pend) begin
            if (ack_cnt == 0) begin
                reg_ack  <= 1'b1;
                reg_data <= reg_value(reg_addr);    // data only in the ack cycle
                ack_pend <= 1'b0;
            end else begin
                ack_cnt <= ack_cnt - 1;
            end
        end
    end

    // spi display writer logging each command when it acks
    always @(posedge clk) begin
        disp_ack <= 1'b0;
        case (disp_st)
            2'd0: if (disp_write) begin
                disp_cnt <= disp_wait_cfg;
                disp_st  <= 2'd1;
            end
            2'd1: if (disp_cnt == 0) begin
                disp_ack <= 1'b1;
                log_addr.push_back(disp_addr);
                log_data.push_back(disp_data);
                disp_st  <= 2'd2;
            end else begin
                disp_cnt <= disp_cnt - 1;
            end
            default: if (!disp_write)
                disp_st <= 2'd0;
        endcase
    end

    // strobe monitor
    always @(posedge clk) begin
        wb_read_q    <= wb_read;
        wb_write_q   <= wb_write;
        disp_write_q <= disp_write;
        reg_cs_q     <= reg_cs;
        if (wb_read && !wb_read_q) begin
            n_wb_rd      <= n_wb_rd + 1;
            seen_wb_addr <= wb_addr;
        end
        if (wb_write && !wb_write_q) begin
            n_wb_wr       <= n_wb_wr + 1;
            seen_wb_addr  <= wb_addr;
            seen_wb_wdata <= wb_wdata;
        end
        if (reg_read) begin
            n_reg_rd      <= n_reg_rd + 1;          // counts cycles so a long pulse shows
            seen_reg_addr <= reg_addr;
            check_value("chip select before register read", reg_cs_q, 1'b1);
        end
        if (disp_write && !disp_write_q)
            n_disp_wr <= n_disp_wr + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the accesses did not finish within %0d cycles", cycle_cnt);
            $display("Checks failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // one access presented on the current edge
    task automatic run_access(input req_kind_t k, input word_t a, input word_t d);
        target_t tgt;
        word_t   exp_data;
        word_t   got;
        int      lat;
        int      rd0;
        int      wr0;
        int      rg0;
        int      dp0;
        int      log0;
        tgt  = expect_target(k, a);
        rd0  = n_wb_rd;
        wr0  = n_wb_wr;
        rg0  = n_reg_rd;
        dp0  = n_disp_wr;
        log0 = log_addr.size();
        req_kind <= k;
        addr     <= a;
        wdata    <= d;
        @(posedge clk);                             // acceptance edge
        check_value("busy before acceptance", cpu_busy, 1'b0);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            check_value("busy while in flight", cpu_busy, 1'b1);
        end while (!done);
        req_kind <= REQ_IDLE;
        case (tgt)
            TGT_WB_RD: exp_data = ref_mem[a[7:2]];
            TGT_REG:   exp_data = reg_value(a[4:0]);
            TGT_NONE:  exp_data = 32'hDEAD_BEEF;
            default:   exp_data = '0;
        endcase
        got = (k == REQ_FETCH) ? instr : rdata;    // fetch result goes to instr
        if (tgt == TGT_WB_RD || tgt == TGT_REG || tgt == TGT_NONE)
            check_value("returned data", got, exp_data);
        if (tgt == TGT_NONE)
            check_value("refused access latency", lat, 4);
        check_value("memory read strobes", n_wb_rd - rd0, tgt == TGT_WB_RD);
        check_value("memory write strobes", n_wb_wr - wr0, tgt == TGT_WB_WR);
        check_value("register read pulses", n_reg_rd - rg0, tgt == TGT_REG);
        check_value("display write strobes", n_disp_wr - dp0, tgt == TGT_DISP);
        check_value("display log entries", log_addr.size() - log0, tgt == TGT_DISP);
        if (tgt == TGT_WB_RD || tgt == TGT_WB_WR)
            check_value("memory address", seen_wb_addr,
                        (a & 32'h00FF_FFFF) | 32'h3300_0000);
        if (tgt == TGT_WB_WR) begin
            check_value("memory store data", seen_wb_wdata, d);
            ref_mem[a[7:2]] = d;
        end
        if (tgt == TGT_REG)
            check_value("register index", seen_reg_addr, a[4:0]);
        if (tgt == TGT_DISP) begin
            check_value("display address", log_addr[log0], a);
            check_value("display data", log_data[log0], d);
        end
        @(posedge clk);                             // one idle cycle
        check_value("done is a single pulse", done, 1'b0);
        check_value("busy after done", cpu_busy, 1'b0);
    endtask

    initial begin
        req_kind_t k;
        word_t     a;
        word_t     d;
        int        n_disp;
        req_kind      = REQ_IDLE;
        addr          = '0;
        wdata         = '0;
        wb_busy       = 1'b0;
        wb_rdata      = '0;
        reg_cs        = 1'b0;
        reg_ack       = 1'b0;
        reg_data      = '0;
        disp_ack      = 1'b0;
        wb_st         = 2'd0;
        wb_cnt        = 0;
        cs_cnt        = 0;
        ack_cnt       = 0;
        ack_pend      = 1'b0;
        disp_st       = 2'd0;
        disp_cnt      = 0;
        n_wb_rd       = 0;
        n_wb_wr       = 0;
        n_reg_rd      = 0;
        n_disp_wr     = 0;
        wb_read_q     = 1'b0;
        wb_write_q    = 1'b0;
        disp_write_q  = 1'b0;
        reg_cs_q      = 1'b0;
        cycle_cnt     = 0;
        wb_wait_cfg   = 0;
        wb_len_cfg    = 1;
        cs_gap_cfg    = 0;
        ack_wait_cfg  = 0;
        disp_wait_cfg = 0;
        n_disp        = 0;
        lfsr_q        = 32'h98ca_50c4;
        for (int i = 0; i < 64; i++) begin
            mem_tgt[i] = mem_fill(i);
            ref_mem[i] = mem_fill(i);
        end
        @(posedge arst_n);
        @(posedge clk);
        check_value("cpu_busy_o after reset", cpu_busy, 1'b0);
        check_value("done_o after reset", done, 1'b0);
        check_value("wb_read_o after reset", wb_read, 1'b0);
        check_value("wb_write_o after reset", wb_write, 1'b0);
        check_value("reg_read_o after reset", reg_read, 1'b0);
        check_value("disp_write_o after reset", disp_write, 1'b0);
        for (int n = 0; n < NUM_ACCESS; n++) begin
            k = req_kind_t'(take_bits(2));
            if (k == REQ_IDLE)
                k = REQ_READ;                       // idle is no access
            a = pick_addr();
            d = take_bits(32);
            wb_wait_cfg   <= take_bits(2);
            wb_len_cfg    <= take_bits(2) + 1;
            cs_gap_cfg    <= take_bits(3);
            ack_wait_cfg  <= take_bits(2);
            disp_wait_cfg <= take_bits(2);
            if (expect_target(k, a) == TGT_DISP)
                n_disp++;
            run_access(k, a, d);
        end
        check_value("display log size", log_addr.size(), n_disp);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;                // reset over the first two edges
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

    always #2 clk_o = ~clk_o;           // 4 ns period

endmodule

//--- design/mmio_bridge.sv
`timescale 1ns/100ps

module mmio_bridge import mmio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    // processor memory handler
    input  req_kind_t req_kind_i,
    input  word_t     addr_i,
    input  word_t     wdata_i,
    output logic      cpu_busy_o,
    output logic      done_o,
    output word_t     rdata_o,
    output word_t     instr_o,
    // wishbone manager
    input  logic      wb_busy_i,
    input  word_t     wb_data_i,
    output logic      wb_read_o,
    output logic      wb_write_o,
    output word_t     wb_addr_o,
    output word_t     wb_data_o,
    // external registers
    input  logic      reg_cs_i,
    input  logic      reg_ack_i,
    input  word_t     reg_data_i,
    output logic      reg_read_o,
    output reg_addr_t reg_addr_o,
    // spi display
    input  logic      disp_ack_i,
    output logic      disp_write_o,
    output word_t     disp_addr_o,
    output word_t     disp_data_o
);

    logic      req_start;      // cpu_port to router
    logic      rsp_done;
    req_kind_t req_kind;
    word_t     req_addr;
    word_t     req_wdata;
    word_t     rsp_data;
    logic      wb_start;       // router to memory side
    logic      wb_wr_sel;
    logic      wb_finish;
    word_t     wb_addr;
    word_t     wb_wdata;
    word_t     wb_rdata;
    logic      reg_start;      // router to register side
    logic      reg_finish;
    reg_addr_t reg_idx;
    word_t     reg_rdata;
    logic      disp_start;     // router to display side
    logic      disp_finish;
    word_t     disp_addr;
    word_t     disp_data;

    cpu_port cpu_port_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_kind_i (req_kind_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .cpu_busy_o (cpu_busy_o),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .instr_o    (instr_o),
        .start_o    (req_start),
        .kind_o     (req_kind),
        .addr_o     (req_addr),
        .wdata_o    (req_wdata),
        .rsp_done_i (rsp_done),
        .rsp_data_i (rsp_data)
    );

    mmio_router mmio_router_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .start_i       (req_start),
        .kind_i        (req_kind),
        .addr_i        (req_addr),
        .wdata_i       (req_wdata),
        .done_o        (rsp_done),
        .data_o        (rsp_data),
        .wb_start_o    (wb_start),
        .wb_write_o    (wb_wr_sel),
        .wb_addr_o     (wb_addr),
        .wb_wdata_o    (wb_wdata),
        .wb_finish_i   (wb_finish),
        .wb_rdata_i    (wb_rdata),
        .reg_start_o   (reg_start),
        .reg_addr_o    (reg_idx),
        .reg_finish_i  (reg_finish),
        .reg_rdata_i   (reg_rdata),
        .disp_start_o  (disp_start),
        .disp_addr_o   (disp_addr),
        .disp_data_o   (disp_data),
        .disp_finish_i (disp_finish)
    );

    wb_port wb_port_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (wb_start),
        .write_i    (wb_wr_sel),
        .addr_i     (wb_addr),
        .wdata_i    (wb_wdata),
        .finish_o   (wb_finish),
        .rdata_o    (wb_rdata),
        .wb_busy_i  (wb_busy_i),
        .wb_data_i  (wb_data_i),
        .wb_read_o  (wb_read_o),
        .wb_write_o (wb_write_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    ext_reg_port ext_reg_port_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (reg_start),
        .addr_i     (reg_idx),
        .finish_o   (reg_finish),
        .rdata_o    (reg_rdata),
        .reg_cs_i   (reg_cs_i),
        .reg_ack_i  (reg_ack_i),
        .reg_data_i (reg_data_i),
        .reg_read_o (reg_read_o),
        .reg_addr_o (reg_addr_o)
    );

    display_port display_port_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (disp_start),
        .addr_i       (disp_addr),
        .data_i       (disp_data),
        .finish_o     (disp_finish),
        .disp_ack_i   (disp_ack_i),
        .disp_write_o (disp_write_o),
        .disp_addr_o  (disp_addr_o),
        .disp_data_o  (disp_data_o)
    );

endmodule

//--- design/display_port.sv
`timescale 1ns/100ps

module display_port import mmio_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  start_i,
    input  word_t addr_i,
    input  word_t data_i,        // store data from processor
    output logic  finish_o,
    input  logic  disp_ack_i,    // spi writer took the command
    output logic  disp_write_o,
    output word_t disp_addr_o,
    output word_t disp_data_o
);

    logic  write_q;
    logic  finish_q;
    word_t addr_q;
    word_t data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            write_q  <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= write_q && disp_ack_i;
            if (start_i)
                write_q <= 1'b1;
            else if (disp_ack_i)
                write_q <= 1'b0;     // level held until ack
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q <= addr_i;        // command latched for the spi side
            data_q <= data_i;
        end
    end

    assign disp_write_o = write_q;
    assign disp_addr_o  = addr_q;
    assign disp_data_o  = data_q;
    assign finish_o     = finish_q;

endmodule

//--- design/ext_reg_port.sv
`timescale 1ns/100ps

module ext_reg_port import mmio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,
    input  reg_addr_t addr_i,
    output logic      finish_o,
    output word_t     rdata_o,
    input  logic      reg_cs_i,    // register bank ready to be read
    input  logic      reg_ack_i,
    input  word_t     reg_data_i,
    output logic      reg_read_o,
    output reg_addr_t reg_addr_o
);

    logic      cs_wait_q;   // step 1, wait chip select
    logic      read_q;      // step 2, one cycle read pulse
    logic      ack_wait_q;  // step 3, wait acknowledge
    logic      finish_q;
    reg_addr_t addr_q;
    word_t     rdata_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cs_wait_q  <= 1'b0;
            read_q     <= 1'b0;
            ack_wait_q <= 1'b0;
            finish_q   <= 1'b0;
        end else begin
            read_q   <= cs_wait_q && reg_cs_i;
            finish_q <= ack_wait_q && reg_ack_i;
            if (start_i)
                cs_wait_q <= 1'b1;
            else if (reg_cs_i)
                cs_wait_q <= 1'b0;
            if (cs_wait_q && reg_cs_i)
                ack_wait_q <= 1'b1;
            else if (reg_ack_i)
                ack_wait_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i)
            addr_q <= addr_i;          // held for the whole access
        if (ack_wait_q && reg_ack_i)
            rdata_q <= reg_data_i;
    end

    assign reg_read_o = read_q;
    assign reg_addr_o = addr_q;
    assign finish_o   = finish_q;
    assign rdata_o    = rdata_q;

endmodule

//--- design/wb_port.sv
`timescale 1ns/100ps

module wb_port import mmio_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  start_i,     // from router
    input  logic  write_i,     // store when set
    input  word_t addr_i,
    input  word_t wdata_i,
    output logic  finish_o,
    output word_t rdata_o,
    input  logic  wb_busy_i,   // manager busy level
    input  word_t wb_data_i,
    output logic  wb_read_o,
    output logic  wb_write_o,
    output word_t wb_addr_o,
    output word_t wb_data_o
);

    logic  rd_q;
    logic  wr_q;
    logic  seen_q;       // busy observed during this access
    logic  busy_prev_q;
    logic  finish_q;
    logic  fall;
    word_t addr_q;
    word_t wdata_q;
    word_t rdata_q;

    // end of the busy phase, only once busy rose for this access
    assign fall = (rd_q || wr_q) && seen_q && busy_prev_q && !wb_busy_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_q        <= 1'b0;
            wr_q        <= 1'b0;
            seen_q      <= 1'b0;
            busy_prev_q <= 1'b0;
            finish_q    <= 1'b0;
        end else begin
            busy_prev_q <= wb_busy_i;
            finish_q    <= fall;
            if (start_i) begin
                rd_q   <= !write_i;
                wr_q   <= write_i;
                seen_q <= 1'b0;
            end else if (fall) begin
                rd_q   <= 1'b0;        // drop strobe after the edge
                wr_q   <= 1'b0;
                seen_q <= 1'b0;
            end else if ((rd_q || wr_q) && wb_busy_i) begin
                seen_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (fall)
            rdata_q <= wb_data_i;      // read word valid at busy fall
    end

    assign wb_read_o  = rd_q;
    assign wb_write_o = wr_q;
    assign wb_addr_o  = addr_q;
    assign wb_data_o  = wdata_q;
    assign finish_o   = finish_q;
    assign rdata_o    = rdata_q;

endmodule

//--- design/mmio_router.sv
`timescale 1ns/100ps
`include "mmio_macros.svh"

module mmio_router import mmio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,        // captured request from cpu_port
    input  req_kind_t kind_i,
    input  word_t     addr_i,
    input  word_t     wdata_i,
    output logic      done_o,
    output word_t     data_o,
    output logic      wb_start_o,
    output logic      wb_write_o,     // store, else read
    output word_t     wb_addr_o,
    output word_t     wb_wdata_o,
    input  logic      wb_finish_i,
    input  word_t     wb_rdata_i,
    output logic      reg_start_o,
    output reg_addr_t reg_addr_o,
    input  logic      reg_finish_i,
    input  word_t     reg_rdata_i,
    output logic      disp_start_o,
    output word_t     disp_addr_o,
    output word_t     disp_data_o,
    input  logic      disp_finish_i
);

    router_state_t state_q;
    region_t       rgn_d;
    region_t       rgn_q;
    req_kind_t     kind_q;
    word_t         addr_q;
    word_t         wdata_q;
    word_t         data_q;
    logic          to_wb;
    logic          to_reg;
    logic          to_disp;
    logic          finish;

    always_comb begin
        rgn_d = RGN_NONE;                       // above the display window
        if (addr_i <= `MMIO_INSTR_TOP)
            rgn_d = RGN_INSTR;
        else if (addr_i <= `MMIO_REG_TOP)
            rgn_d = RGN_EXTREG;
        else if (addr_i <= `MMIO_DATA_TOP)
            rgn_d = RGN_DATA;
        else if (addr_i <= `MMIO_DISP_TOP)
            rgn_d = RGN_DISPLAY;
    end

    // decode rules, anything not listed is refused
    assign to_wb   = ((rgn_q == RGN_INSTR || rgn_q == RGN_DATA) &&
                      (kind_q == REQ_FETCH || kind_q == REQ_READ)) ||
                     (rgn_q == RGN_DATA && kind_q == REQ_WRITE);  // no store to instr
    assign to_reg  = (rgn_q == RGN_EXTREG) && (kind_q == REQ_READ);   // read only
    assign to_disp = (rgn_q == RGN_DISPLAY) && (kind_q == REQ_WRITE); // write only
    assign finish  = wb_finish_i || reg_finish_i || disp_finish_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RT_IDLE;
            rgn_q   <= RGN_NONE;
            kind_q  <= REQ_IDLE;
        end else begin
            case (state_q)
                RT_IDLE: if (start_i) begin
                    state_q <= RT_DISPATCH;
                    rgn_q   <= rgn_d;
                    kind_q  <= kind_i;
                end
                RT_DISPATCH: state_q <= (to_wb || to_reg || to_disp) ? RT_WAIT : RT_DONE;
                RT_WAIT:     if (finish) state_q <= RT_DONE;  // stall on slow target
                default:     state_q <= RT_IDLE;              // RT_DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RT_IDLE && start_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (state_q == RT_DISPATCH && !(to_wb || to_reg || to_disp))
            data_q <= `MMIO_ERR_WORD;
        else if (state_q == RT_WAIT && wb_finish_i)
            data_q <= wb_rdata_i;
        else if (state_q == RT_WAIT && reg_finish_i)
            data_q <= reg_rdata_i;
        else if (state_q == RT_WAIT && disp_finish_i)
            data_q <= '0;                               // display gives no data
    end

    assign wb_start_o   = (state_q == RT_DISPATCH) && to_wb;
    assign reg_start_o  = (state_q == RT_DISPATCH) && to_reg;
    assign disp_start_o = (state_q == RT_DISPATCH) && to_disp;
    assign wb_write_o   = (kind_q == REQ_WRITE);
    assign wb_addr_o    = {`MMIO_MEM_PAGE, addr_q[23:0]};  // memory page byte on top
    assign wb_wdata_o   = wdata_q;
    assign reg_addr_o   = addr_q[4:0];
    assign disp_addr_o  = addr_q;
    assign disp_data_o  = wdata_q;
    assign done_o       = (state_q == RT_DONE);
    assign data_o       = data_q;

endmodule

//--- design/cpu_port.sv
`timescale 1ns/100ps

module cpu_port import mmio_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  req_kind_t req_kind_i,  // from memory handler
    input  word_t     addr_i,
    input  word_t     wdata_i,
    output logic      cpu_busy_o,
    output logic      done_o,      // one cycle, result valid
    output word_t     rdata_o,     // load or register data
    output word_t     instr_o,     // fetched instruction
    output logic      start_o,     // request pulse to router
    output req_kind_t kind_o,
    output word_t     addr_o,
    output word_t     wdata_o,
    input  logic      rsp_done_i,
    input  word_t     rsp_data_i
);

    logic      busy_q;
    logic      done_q;
    logic      start_q;
    logic      accept;
    req_kind_t kind_q;
    word_t     addr_q;
    word_t     wdata_q;
    word_t     rdata_q;
    word_t     instr_q;

    assign accept = !busy_q && (req_kind_i != REQ_IDLE); // one access in flight

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
            kind_q  <= REQ_IDLE;
        end else begin
            start_q <= accept;          // req_start one cycle after accept
            done_q  <= rsp_done_i;
            if (accept) begin
                busy_q <= 1'b1;
                kind_q <= req_kind_i;   // fetch vs load steers the result
            end else if (done_q) begin
                busy_q <= 1'b0;         // busy covers the done cycle too
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (rsp_done_i) begin
            if (kind_q == REQ_FETCH)
                instr_q <= rsp_data_i;  // goes to fetch stage
            else
                rdata_q <= rsp_data_i;  // goes to internal memory
        end
    end

    assign cpu_busy_o = busy_q;
    assign done_o     = done_q;
    assign rdata_o    = rdata_q;
    assign instr_o    = instr_q;
    assign start_o    = start_q;
    assign kind_o     = kind_q;
    assign addr_o     = addr_q;
    assign wdata_o    = wdata_q;

endmodule

//--- design/mmio_pkg.sv
package mmio_pkg;

    typedef logic [31:0] word_t;     // address or data word
    typedef logic [4:0]  reg_addr_t; // external register index

    // processor access kind, same coding as the handler's rwi lines
    typedef enum logic [1:0] {
        REQ_IDLE  = 2'b00,
        REQ_WRITE = 2'b01,  // store
        REQ_READ  = 2'b10,  // load
        REQ_FETCH = 2'b11   // instruction fetch
    } req_kind_t;

    typedef enum logic [2:0] {
        RGN_INSTR,
        RGN_EXTREG,
        RGN_DATA,
        RGN_DISPLAY,
        RGN_NONE            // outside the map
    } region_t;

    // access sequencer inside the router
    typedef enum logic [1:0] {
        RT_IDLE,
        RT_DISPATCH,        // decode done, start pulse to a target
        RT_WAIT,            // target busy
        RT_DONE             // result back to cpu_port
    } router_state_t;

endpackage

//--- design/mmio_macros.svh
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

// address map of the bridge, all bounds inclusive
// region starts at the previous top plus one

// instruction memory, 0 .. 1024
`define MMIO_INSTR_TOP 32'd1024

// external registers filled by the microcontroller
`define MMIO_REG_TOP 32'd1056

// data memory
`define MMIO_DATA_TOP 32'd1792

// spi display window, anything above is unmapped
`define MMIO_DISP_TOP 32'd2047

`define MMIO_MEM_PAGE 8'h33          // top byte of every memory address
`define MMIO_ERR_WORD 32'hDEADBEEF   // returned for unmapped or refused access

`endif
